// File: files.f
+incdir+include
hw/cpu_pkg.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/rob_ptr_counter.sv
hw/reorder_buffer.sv
hw/commit_ctrl.sv
hw/rename_stage_top.sv
verification/tb_rename_stage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_rename_stage
FILELIST  = files.f

SOURCES = $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
SIM_BIN = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: verification/tb_rename_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module tb_rename_stage
    import cpu_pkg::*;
();

    localparam int NUM_CYCLES  = 4000;
    localparam int DRAIN_LIMIT = 200;

    logic               clk = 1'b0;
    logic               rst;
    logic               rdy;
    logic               inst_valid;
    logic [31:0]        inst;
    logic [`XLEN-1:0]   pc;
    logic               wb_en;
    logic [`TAG_W-1:0]  wb_tag;
    logic [`XLEN-1:0]   wb_data;
    logic               flush;

    logic               dp_en;
    op_e                dp_op;
    logic [`NAME_W-1:0] dp_rd;
    logic               dp_pd;
    logic [`XLEN-1:0]   dp_pc;
    logic [`XLEN-1:0]   dp_imm;
    logic [`TAG_W-1:0]  dp_tag;
    logic [`TAG_W-1:0]  dp_rs1_tag;
    logic [`TAG_W-1:0]  dp_rs2_tag;
    logic [`XLEN-1:0]   dp_rs1_data;
    logic [`XLEN-1:0]   dp_rs2_data;
    logic               issue_stall;
    logic               commit_en;
    logic [`NAME_W-1:0] commit_rd;
    logic [`XLEN-1:0]   commit_data;

    // reference model of the rename table and the reorder buffer
    logic [`XLEN-1:0]   m_arch  [`REG_NUM];
    int                 m_tag   [`REG_NUM];
    logic [`NAME_W-1:0] q_rd    [`ROB_DEPTH];
    logic               q_pd    [`ROB_DEPTH];
    logic               q_ready [`ROB_DEPTH];
    logic [`XLEN-1:0]   q_data  [`ROB_DEPTH];
    int                 m_head;
    int                 m_tail;
    int                 m_count;
    commit_state_e      m_state;

    // instruction held by the source until it is accepted
    logic               have_inst;
    logic [31:0]        cur_inst;
    logic [31:0]        cur_pc;
    op_e                cur_op;
    logic [`NAME_W-1:0] cur_rs1;
    logic [`NAME_W-1:0] cur_rs2;
    logic [`NAME_W-1:0] cur_rd;
    logic [31:0]        cur_imm;
    logic               cur_pd;

    logic               n_rdy;
    logic               n_flush;
    logic               n_valid;
    logic               n_wb_en;
    logic [`TAG_W-1:0]  n_wb_tag;
    logic [`XLEN-1:0]   n_wb_data;
    int                 low_left;

    logic               accept;
    logic               retire;
    logic [31:0]        rng;
    int                 cycle;
    int                 drain_wait;
    int                 checks;
    int                 errors;
    int                 timeouts;

    always #4 clk = ~clk;

    rename_stage_top rename_stage_top_inst (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .pc          (pc),
        .wb_en       (wb_en),
        .wb_tag      (wb_tag),
        .wb_data     (wb_data),
        .flush       (flush),
        .dp_en       (dp_en),
        .dp_op       (dp_op),
        .dp_rd       (dp_rd),
        .dp_pd       (dp_pd),
        .dp_pc       (dp_pc),
        .dp_imm      (dp_imm),
        .dp_tag      (dp_tag),
        .dp_rs1_tag  (dp_rs1_tag),
        .dp_rs2_tag  (dp_rs2_tag),
        .dp_rs1_data (dp_rs1_data),
        .dp_rs2_data (dp_rs2_data),
        .issue_stall (issue_stall),
        .commit_en   (commit_en),
        .commit_rd   (commit_rd),
        .commit_data (commit_data)
    );

    function automatic logic [31:0] rand_next();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < `REG_NUM; i++) begin
            m_arch[i] = '0;
            m_tag[i]  = 0;
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            q_rd[i]    = '0;
            q_pd[i]    = 1'b0;
            q_ready[i] = 1'b0;
            q_data[i]  = '0;
        end
        m_head  = 0;
        m_tail  = 0;
        m_count = 0;
        m_state = st_run;
    endtask

    // builds an RV32I word from chosen fields and records its expected decode
    task automatic build_inst();
        logic [31:0] r;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [4:0]  d;
        logic [11:0] i12;
        logic [12:0] b13;
        logic [2:0]  f3;
        logic        alt;
        logic        writes;
        int          cls;
        r   = rand_next();
        // registers stay in x0..x7 so that renaming conflicts are frequent
        s1  = {2'b00, r[2:0]};
        s2  = {2'b00, r[5:3]};
        d   = {2'b00, r[8:6]};
        f3  = r[11:9];
        alt = r[12];
        i12 = r[24:13];
        b13 = {r[31:20], 1'b0};
        cls = int'(rand_next() % 32'd5);
        cur_pc  = cur_pc + 32'd4;
        cur_rs1 = s1;
        cur_rs2 = 5'd0;
        cur_imm = {{20{i12[11]}}, i12};
        writes  = 1'b1;
        case (cls)
            0: begin
                alt      = alt && (f3 == 3'd0 || f3 == 3'd5);
                cur_inst = {1'b0, alt, 5'b0, s2, s1, f3, d, 7'b0110011};
                cur_rs2  = s2;
                cur_imm  = '0;
                case (f3)
                    3'd0:    cur_op = alt ? op_sub : op_add;
                    3'd1:    cur_op = op_sll;
                    3'd2:    cur_op = op_slt;
                    3'd3:    cur_op = op_sltu;
                    3'd4:    cur_op = op_xor;
                    3'd5:    cur_op = alt ? op_sra : op_srl;
                    3'd6:    cur_op = op_or;
                    default: cur_op = op_and;
                endcase
            end
            1: begin
                // shifts carry funct7 in the upper immediate bits
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    alt     = alt && (f3 == 3'd5);
                    i12     = {1'b0, alt, 5'b0, i12[4:0]};
                    cur_imm = {20'd0, i12};
                end
                cur_inst = {i12, s1, f3, d, 7'b0010011};
                case (f3)
                    3'd0:    cur_op = op_addi;
                    3'd1:    cur_op = op_slli;
                    3'd2:    cur_op = op_slti;
                    3'd3:    cur_op = op_sltiu;
                    3'd4:    cur_op = op_xori;
                    3'd5:    cur_op = alt ? op_srai : op_srli;
                    3'd6:    cur_op = op_ori;
                    default: cur_op = op_andi;
                endcase
            end
            2: begin
                f3       = (f3 == 3'd3 || f3 >= 3'd6) ? 3'd2 : f3;
                cur_inst = {i12, s1, f3, d, 7'b0000011};
                case (f3)
                    3'd0:    cur_op = op_lb;
                    3'd1:    cur_op = op_lh;
                    3'd2:    cur_op = op_lw;
                    3'd4:    cur_op = op_lbu;
                    default: cur_op = op_lhu;
                endcase
            end
            3: begin
                f3       = (f3 > 3'd2) ? 3'd2 : f3;
                cur_inst = {i12[11:5], s2, s1, f3, i12[4:0], 7'b0100011};
                cur_rs2  = s2;
                writes   = 1'b0;
                case (f3)
                    3'd0:    cur_op = op_sb;
                    3'd1:    cur_op = op_sh;
                    default: cur_op = op_sw;
                endcase
            end
            default: begin
                f3       = (f3 == 3'd2 || f3 == 3'd3) ? 3'd0 : f3;
                cur_inst = {b13[12], b13[10:5], s2, s1, f3, b13[4:1], b13[11], 7'b1100011};
                cur_rs2  = s2;
                cur_imm  = {{19{b13[12]}}, b13};
                writes   = 1'b0;
                case (f3)
                    3'd0:    cur_op = op_beq;
                    3'd1:    cur_op = op_bne;
                    3'd4:    cur_op = op_blt;
                    3'd5:    cur_op = op_bge;
                    3'd6:    cur_op = op_bltu;
                    default: cur_op = op_bgeu;
                endcase
            end
        endcase
        cur_rd = writes ? d : 5'd0;
        cur_pd = writes && (d != 5'd0);
    endtask

    task automatic pick_stimulus(input logic drain);
        int wb_pct;
        int pick;
        int idx;
        int cand [$];
        if (drain) begin
            n_rdy = 1'b1;
        end else if (low_left > 0) begin
            n_rdy    = 1'b0;
            low_left = low_left - 1;
        end else if (rand_next() % 32'd40 == 32'd0) begin
            n_rdy    = 1'b0;
            low_left = int'(rand_next() % 32'd4);
        end else begin
            n_rdy = 1'b1;
        end
        n_flush = !drain && (rand_next() % 32'd90 == 32'd0);
        if (!drain && !have_inst && (rand_next() % 32'd4 != 32'd0)) begin
            build_inst();
            have_inst = 1'b1;
        end
        n_valid = have_inst && !drain;

        // only entries still waiting for a result get one, in random order
        for (int i = 0; i < m_count; i++) begin
            idx = (m_head + i) % `ROB_DEPTH;
            if (!q_ready[idx])
                cand.push_back(idx);
        end
        // alternate slow and fast writeback phases so the buffer also fills up
        wb_pct    = drain ? 100 : (((cycle / 150) % 2 == 0) ? 15 : 70);
        n_wb_en   = 1'b0;
        n_wb_tag  = 4'(rand_next());
        n_wb_data = rand_next();
        if (cand.size() > 0 && int'(rand_next() % 32'd100) < wb_pct) begin
            pick     = int'(rand_next() % 32'(cand.size()));
            n_wb_en  = 1'b1;
            n_wb_tag = 4'(cand[pick] + 1);
        end else if (!drain && (rand_next() % 32'd20 == 32'd0)) begin
            // a stale result for an entry that is not in flight must be dropped
            idx     = int'(n_wb_tag) - 1;
            n_wb_en = (idx < 0) || (idx >= `ROB_DEPTH) ||
                      (((idx - m_head + `ROB_DEPTH) % `ROB_DEPTH) >= m_count);
        end
    endtask

    task automatic compare_outputs();
        logic exp_stall;
        exp_stall = (m_count == `ROB_DEPTH) || (m_state != st_run) || !rdy;
        accept    = inst_valid && !exp_stall;
        retire    = (m_state == st_run) && rdy && (m_count != 0) && q_ready[m_head];
        check_value("issue_stall", 32'(exp_stall), 32'(issue_stall));
        check_value("dp_en", 32'(accept), 32'(dp_en));
        check_value("commit_en", 32'(retire), 32'(commit_en));
        if (accept) begin
            check_value("dp_op", 32'(cur_op), 32'(dp_op));
            check_value("dp_rd", 32'(cur_rd), 32'(dp_rd));
            check_value("dp_pd", 32'(cur_pd), 32'(dp_pd));
            check_value("dp_imm", cur_imm, dp_imm);
            check_value("dp_pc", cur_pc, dp_pc);
            check_value("dp_tag", m_tail + 1, 32'(dp_tag));
            check_value("dp_rs1_tag", m_tag[cur_rs1], 32'(dp_rs1_tag));
            check_value("dp_rs2_tag", m_tag[cur_rs2], 32'(dp_rs2_tag));
            check_value("dp_rs1_data", m_arch[cur_rs1], dp_rs1_data);
            check_value("dp_rs2_data", m_arch[cur_rs2], dp_rs2_data);
        end
        if (retire) begin
            check_value("commit_rd", 32'(q_rd[m_head]), 32'(commit_rd));
            check_value("commit_data", q_data[m_head], commit_data);
        end
    endtask

    // applies this cycle's effects as they land at the next rising edge
    task automatic advance_model();
        int   idx;
        int   rd;
        logic live;
        idx  = int'(wb_tag) - 1;
        live = wb_en && rdy && (idx >= 0) && (idx < `ROB_DEPTH) &&
               (((idx - m_head + `ROB_DEPTH) % `ROB_DEPTH) < m_count);
        if (m_state == st_flush) begin
            m_head  = 0;
            m_tail  = 0;
            m_count = 0;
            for (int i = 0; i < `REG_NUM; i++)
                m_tag[i] = 0;
        end else begin
            if (retire) begin
                rd = int'(q_rd[m_head]);
                if (q_pd[m_head]) begin
                    m_arch[rd] = q_data[m_head];
                    // an older producer must not clear a younger one's tag
                    if (m_tag[rd] == m_head + 1)
                        m_tag[rd] = 0;
                end
                m_head  = (m_head + 1) % `ROB_DEPTH;
                m_count = m_count - 1;
            end
            if (live) begin
                q_ready[idx] = 1'b1;
                q_data[idx]  = wb_data;
            end
            if (accept) begin
                q_rd[m_tail]    = cur_rd;
                q_pd[m_tail]    = cur_pd;
                q_ready[m_tail] = 1'b0;
                if (cur_pd)
                    m_tag[cur_rd] = m_tail + 1;
                m_tail    = (m_tail + 1) % `ROB_DEPTH;
                m_count   = m_count + 1;
                have_inst = 1'b0;
            end
        end
        if (m_state == st_flush)
            m_state = rdy ? st_run : st_stall;
        else if (!rdy)
            m_state = st_stall;
        else if (flush)
            m_state = st_flush;
        else
            m_state = st_run;
    endtask

    task automatic run_cycle(input logic drain);
        @(negedge clk);
        compare_outputs();
        advance_model();
        pick_stimulus(drain);
        @(posedge clk);
        rdy        <= n_rdy;
        flush      <= n_flush;
        inst_valid <= n_valid;
        inst       <= cur_inst;
        pc         <= cur_pc;
        wb_en      <= n_wb_en;
        wb_tag     <= n_wb_tag;
        wb_data    <= n_wb_data;
    endtask

    initial begin
        rng        = 32'h0221_cbe7;
        rst        = 1'b1;
        rdy        = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        wb_en      = 1'b0;
        wb_tag     = '0;
        wb_data    = '0;
        flush      = 1'b0;
        have_inst  = 1'b0;
        cur_inst   = '0;
        cur_pc     = 32'h0000_0ffc;
        low_left   = 0;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        reset_model();

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        rdy <= 1'b1;

        for (cycle = 0; cycle < NUM_CYCLES; cycle++)
            run_cycle(1'b0);

        // stop issuing and let every in-flight entry finish and retire
        drain_wait = 0;
        while (m_count != 0 && drain_wait < DRAIN_LIMIT) begin
            run_cycle(1'b1);
            drain_wait++;
        end
        if (m_count != 0) begin
            timeouts++;
            $display("timeout: reorder buffer still holds %0d entries after %0d cycles",
                     m_count, DRAIN_LIMIT);
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/rename_stage_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module rename_stage_top
    import cpu_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        rdy,

    input  wire        inst_valid,
    input  wire [31:0] inst,
    input  wire data_t pc,

    input  wire        wb_en,
    input  wire tag_t  wb_tag,
    input  wire data_t wb_data,

    input  wire        flush,

    output logic       dp_en,
    output op_e        dp_op,
    output name_t      dp_rd,
    output logic       dp_pd,
    output data_t      dp_pc,
    output data_t      dp_imm,
    output tag_t       dp_tag,
    output tag_t       dp_rs1_tag,
    output tag_t       dp_rs2_tag,
    output data_t      dp_rs1_data,
    output data_t      dp_rs2_data,

    output logic       issue_stall,

    output logic       commit_en,
    output name_t      commit_rd,
    output data_t      commit_data
);

    name_t rs1_name;
    name_t rs2_name;
    ptr_t  head;
    ptr_t  tail;
    logic  full;
    logic  empty;
    logic  clr;
    logic  running;
    logic  head_ready;
    logic  head_pd;
    tag_t  head_tag;
    logic  wb_accept;

    inst_decoder inst_decoder_inst (
        .inst (inst),
        .op   (dp_op),
        .rs1  (rs1_name),
        .rs2  (rs2_name),
        .rd   (dp_rd),
        .imm  (dp_imm),
        .pd   (dp_pd)
    );

    assign issue_stall = full || !running || !rdy;
    assign dp_en       = inst_valid && !issue_stall;
    assign dp_pc       = pc;
    assign dp_tag      = tag_t'(tail) + tag_t'(1);
    assign head_tag    = tag_t'(head) + tag_t'(1);

    // results arriving while the stage is frozen are not recorded
    assign wb_accept   = wb_en && rdy;

    regfile regfile_inst (
        .clk         (clk),
        .rst         (rst),
        .clr         (clr),
        .rs1         (rs1_name),
        .rs2         (rs2_name),
        .rs1_data    (dp_rs1_data),
        .rs2_data    (dp_rs2_data),
        .rs1_tag     (dp_rs1_tag),
        .rs2_tag     (dp_rs2_tag),
        .alloc_en    (dp_en && dp_pd),
        .alloc_rd    (dp_rd),
        .alloc_tag   (dp_tag),
        .commit_en   (commit_en && head_pd),
        .commit_rd   (commit_rd),
        .commit_tag  (head_tag),
        .commit_data (commit_data)
    );

    rob_ptr_counter rob_ptr_counter_inst (
        .clk   (clk),
        .rst   (rst),
        .clr   (clr),
        .push  (dp_en),
        .pop   (commit_en),
        .head  (head),
        .tail  (tail),
        .full  (full),
        .empty (empty)
    );

    reorder_buffer reorder_buffer_inst (
        .clk        (clk),
        .alloc_en   (dp_en),
        .alloc_idx  (tail),
        .alloc_rd   (dp_rd),
        .alloc_pd   (dp_pd),
        .wb_en      (wb_accept),
        .wb_tag     (wb_tag),
        .wb_data    (wb_data),
        .head       (head),
        .empty      (empty),
        .head_ready (head_ready),
        .head_rd    (commit_rd),
        .head_pd    (head_pd),
        .head_data  (commit_data)
    );

    commit_ctrl commit_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .flush      (flush),
        .head_ready (head_ready),
        .empty      (empty),
        .commit_en  (commit_en),
        .clr        (clr),
        .running    (running)
    );

endmodule

`default_nettype wire

// File: hw/commit_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module commit_ctrl
    import cpu_pkg::*;
(
    input  wire  clk,
    input  wire  rst,
    input  wire  rdy,
    input  wire  flush,
    input  wire  head_ready,
    input  wire  empty,
    output logic commit_en,
    output logic clr,
    output logic running
);

    commit_state_e state;
    commit_state_e state_next;

    always_comb begin
        case (state)
            st_run, st_stall: begin
                // a dropped rdy wins over a flush request in the same cycle
                if (!rdy)
                    state_next = st_stall;
                else if (flush)
                    state_next = st_flush;
                else
                    state_next = st_run;
            end
            st_flush: state_next = rdy ? st_run : st_stall;
            default:  state_next = st_run;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= st_run;
        else
            state <= state_next;
    end

    // retire only a finished head entry, and never during the flush cycle
    assign commit_en = (state == st_run) && rdy && !empty && head_ready;
    assign clr       = (state == st_flush);
    assign running   = (state == st_run);

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module reorder_buffer
    import cpu_pkg::*;
(
    input  wire        clk,

    input  wire        alloc_en,
    input  wire ptr_t  alloc_idx,
    input  wire name_t alloc_rd,
    input  wire        alloc_pd,

    input  wire        wb_en,
    input  wire tag_t  wb_tag,
    input  wire data_t wb_data,

    input  wire ptr_t  head,
    input  wire        empty,
    output logic       head_ready,
    output name_t      head_rd,
    output logic       head_pd,
    output data_t      head_data
);

    name_t ent_rd    [`ROB_DEPTH];
    logic  ent_pd    [`ROB_DEPTH];
    logic  ent_ready [`ROB_DEPTH];
    data_t ent_data  [`ROB_DEPTH];

    ptr_t wb_idx;
    ptr_t wb_off;
    ptr_t tail_off;
    logic tag_ok;
    logic wb_live;

    assign wb_idx = wb_tag[`PTR_W-1:0] - ptr_t'(1);
    assign tag_ok = (wb_tag != '0) && (wb_tag <= tag_t'(`ROB_DEPTH));

    // distance from head decides whether the entry sits between head and tail
    // tail_off of zero with a non-empty buffer means every entry is live
    assign wb_off   = wb_idx - head;
    assign tail_off = alloc_idx - head;
    assign wb_live  = wb_en && tag_ok && !empty &&
                      ((tail_off == '0) || (wb_off < tail_off));

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            ent_rd[alloc_idx]    <= alloc_rd;
            ent_pd[alloc_idx]    <= alloc_pd;
            ent_ready[alloc_idx] <= 1'b0;
        end
        if (wb_live) begin
            ent_ready[wb_idx] <= 1'b1;
            ent_data[wb_idx]  <= wb_data;
        end
    end

    assign head_ready = ent_ready[head];
    assign head_rd    = ent_rd[head];
    assign head_pd    = ent_pd[head];
    assign head_data  = ent_data[head];

endmodule

`default_nettype wire

// File: hw/rob_ptr_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module rob_ptr_counter
    import cpu_pkg::*;
(
    input  wire  clk,
    input  wire  rst,
    input  wire  clr,
    input  wire  push,
    input  wire  pop,
    output ptr_t head,
    output ptr_t tail,
    output logic full,
    output logic empty
);

    localparam cnt_t full_count = `ROB_DEPTH;

    cnt_t count;

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pointers wrap naturally at the power-of-two depth
            if (push)
                tail <= tail + ptr_t'(1);
            if (pop)
                head <= head + ptr_t'(1);

            case ({push, pop})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

    assign full  = (count == full_count);
    assign empty = (count == '0);

endmodule

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module regfile
    import cpu_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        clr,

    input  wire name_t rs1,
    input  wire name_t rs2,
    output data_t      rs1_data,
    output data_t      rs2_data,
    output tag_t       rs1_tag,
    output tag_t       rs2_tag,

    input  wire        alloc_en,
    input  wire name_t alloc_rd,
    input  wire tag_t  alloc_tag,

    input  wire        commit_en,
    input  wire name_t commit_rd,
    input  wire tag_t  commit_tag,
    input  wire data_t commit_data
);

    data_t reg_dt  [`REG_NUM];
    tag_t  reg_tag [`REG_NUM];

    // operand read sees the state from before this cycle's edge
    assign rs1_data = (rs1 == '0) ? '0 : reg_dt[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : reg_dt[rs2];
    assign rs1_tag  = (rs1 == '0) ? '0 : reg_tag[rs1];
    assign rs2_tag  = (rs2 == '0) ? '0 : reg_tag[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                reg_dt[i]  <= '0;
                reg_tag[i] <= '0;
            end
        end else begin
            if (commit_en) begin
                reg_dt[commit_rd] <= commit_data;
                // a younger producer may already own rd, leave its tag alone then
                if (reg_tag[commit_rd] == commit_tag)
                    reg_tag[commit_rd] <= '0;
            end

            // same-cycle allocation to rd overrides the clear above
            if (alloc_en)
                reg_tag[alloc_rd] <= alloc_tag;

            if (clr) begin
                for (int i = 0; i < `REG_NUM; i++)
                    reg_tag[i] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module inst_decoder
    import cpu_pkg::*;
(
    input  wire [31:0] inst,
    output op_e        op,
    output name_t      rs1,
    output name_t      rs2,
    output name_t      rd,
    output data_t      imm,
    output logic       pd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       use_rs1;
    logic       use_rs2;
    logic       write_rd;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        op       = op_invalid;
        imm      = '0;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        write_rd = 1'b0;

        case (opcode)
            7'b0110111: begin
                op       = op_lui;
                imm      = {inst[31:12], 12'b0};
                write_rd = 1'b1;
            end
            7'b0010111: begin
                op       = op_auipc;
                imm      = {inst[31:12], 12'b0};
                write_rd = 1'b1;
            end
            7'b1101111: begin
                op       = op_jal;
                imm      = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                write_rd = 1'b1;
            end
            7'b1100111: begin
                if (funct3 == 3'b000)
                    op = op_jalr;
                imm      = {{20{inst[31]}}, inst[31:20]};
                use_rs1  = 1'b1;
                write_rd = 1'b1;
            end
            7'b1100011: begin
                case (funct3)
                    3'b000:  op = op_beq;
                    3'b001:  op = op_bne;
                    3'b100:  op = op_blt;
                    3'b101:  op = op_bge;
                    3'b110:  op = op_bltu;
                    3'b111:  op = op_bgeu;
                    default: op = op_invalid;
                endcase
                imm     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            7'b0000011: begin
                case (funct3)
                    3'b000:  op = op_lb;
                    3'b001:  op = op_lh;
                    3'b010:  op = op_lw;
                    3'b100:  op = op_lbu;
                    3'b101:  op = op_lhu;
                    default: op = op_invalid;
                endcase
                imm      = {{20{inst[31]}}, inst[31:20]};
                use_rs1  = 1'b1;
                write_rd = 1'b1;
            end
            7'b0100011: begin
                case (funct3)
                    3'b000:  op = op_sb;
                    3'b001:  op = op_sh;
                    3'b010:  op = op_sw;
                    default: op = op_invalid;
                endcase
                imm     = {{21{inst[31]}}, inst[30:25], inst[11:7]};
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            7'b0010011: begin
                case (funct3)
                    3'b000:  op = op_addi;
                    3'b010:  op = op_slti;
                    3'b011:  op = op_sltiu;
                    3'b100:  op = op_xori;
                    3'b110:  op = op_ori;
                    3'b111:  op = op_andi;
                    3'b001:  op = (funct7 == 7'b0000000) ? op_slli : op_invalid;
                    default: begin
                        if (funct7 == 7'b0000000)
                            op = op_srli;
                        else if (funct7 == 7'b0100000)
                            op = op_srai;
                    end
                endcase
                imm      = {{20{inst[31]}}, inst[31:20]};
                use_rs1  = 1'b1;
                write_rd = 1'b1;
            end
            7'b0110011: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: op = op_add;
                    {7'b0100000, 3'b000}: op = op_sub;
                    {7'b0000000, 3'b001}: op = op_sll;
                    {7'b0000000, 3'b010}: op = op_slt;
                    {7'b0000000, 3'b011}: op = op_sltu;
                    {7'b0000000, 3'b100}: op = op_xor;
                    {7'b0000000, 3'b101}: op = op_srl;
                    {7'b0100000, 3'b101}: op = op_sra;
                    {7'b0000000, 3'b110}: op = op_or;
                    {7'b0000000, 3'b111}: op = op_and;
                    default:              op = op_invalid;
                endcase
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                write_rd = 1'b1;
            end
            default: op = op_invalid;
        endcase

        // an unknown encoding neither reads nor writes anything
        if (op == op_invalid) begin
            imm      = '0;
            use_rs1  = 1'b0;
            use_rs2  = 1'b0;
            write_rd = 1'b0;
        end
    end

    // unused source fields are steered to x0
    assign rs1 = use_rs1 ? inst[19:15] : '0;
    assign rs2 = use_rs2 ? inst[24:20] : '0;
    assign rd  = write_rd ? inst[11:7] : '0;
    assign pd  = write_rd && (inst[11:7] != '0);

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]   data_t;
    typedef logic [`NAME_W-1:0] name_t;
    typedef logic [`TAG_W-1:0]  tag_t;
    typedef logic [`PTR_W-1:0]  ptr_t;

    // occupancy runs from 0 to ROB_DEPTH inclusive
    typedef logic [`PTR_W:0]    cnt_t;

    // one member per RV32I instruction, grouped by major opcode
    typedef enum logic [5:0] {
        op_invalid,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_lbu, op_lhu,
        op_sb, op_sh, op_sw,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and
    } op_e;

    typedef enum logic [1:0] {
        st_run,
        st_flush,
        st_stall
    } commit_state_e;

endpackage

`default_nettype wire

// File: include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and architectural register file
`define XLEN      32
`define REG_NUM   32
`define NAME_W    5

// reorder buffer geometry
`define ROB_DEPTH 8
`define PTR_W     3

// a tag is the entry index plus one, so zero can mean "not renamed"
`define TAG_W     4

`endif
